// File: bench/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS    = 5,   // 10 ns period
  parameter int RST_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_NS o_clk = ~o_clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

// File: bench/tb_core.sv
// integer core testbench
`timescale 1ns/1ps

module tb_core;

  localparam int N_DIR  = 34;   // directed instructions
  localparam int N_RAND = 300;  // random slots
  localparam int LIMIT  = 16 + 2 * (N_DIR + N_RAND) + 100;

  typedef logic [31:0][31:0] regs_t;
  typedef struct packed {
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
    int          edge_no;  // monitor edge where it must show up
  } exp_t;

  logic        i_clk, i_rst, i_ins_valid;
  logic [31:0] i_ins;
  logic        o_wb_valid, o_illegal;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data, o_retire_cnt;

  regs_t       model_regs;
  exp_t        exp_q[$];
  int          seed = 37122;
  int          cycle = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          legal_cnt = 0;

  tb_clk_gen #(.HALF_NS(5), .RST_CYCLES(16)) u_clk_gen (.o_clk(i_clk), .o_rst(i_rst));

  core_top #(.XLEN(32)) u_dut (
    .i_clk        (i_clk       ),
    .i_rst        (i_rst       ),
    .i_ins_valid  (i_ins_valid ),
    .i_ins        (i_ins       ),
    .o_wb_valid   (o_wb_valid  ),
    .o_wb_rd      (o_wb_rd     ),
    .o_wb_data    (o_wb_data   ),
    .o_illegal    (o_illegal   ),
    .o_retire_cnt (o_retire_cnt)
  );

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // rv32i encoders
  function automatic logic [31:0] op_r(input logic [2:0] f3, input logic [6:0] f7,
                                       input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] op_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] op_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, core_pkg::OPC_LUI};
  endfunction

  // rv32i reference model returning legality
  function automatic logic ref_exec(input logic [31:0] ins, input regs_t regs,
                                    output logic [4:0] rd, output logic [31:0] res);
    logic [31:0] a, b, imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    a   = (ins[19:15] == 5'd0) ? 32'd0 : regs[ins[19:15]];
    b   = (ins[24:20] == 5'd0) ? 32'd0 : regs[ins[24:20]];
    imm = {{20{ins[31]}}, ins[31:20]};
    res = 32'd0;
    ok  = 1'b0;
    if (ins[6:0] == core_pkg::OPC_LUI) begin
      ok  = 1'b1;
      res = {ins[31:12], 12'd0};
    end else if (ins[6:0] == core_pkg::OPC_OP_IMM) begin
      ok = (f3 == 3'd0) || (f3 == 3'd4) || (f3 == 3'd6) || (f3 == 3'd7);
      case (f3)
        3'd0: res = a + imm;
        3'd4: res = a ^ imm;
        3'd6: res = a | imm;
        3'd7: res = a & imm;
        default: res = 32'd0;
      endcase
    end else if (ins[6:0] == core_pkg::OPC_OP) begin
      ok = (f7 == 7'd0 && f3 != 3'd3) || (f7 == 7'h20 && f3 == 3'd0);
      case (f3)
        3'd0: res = (f7 == 7'h20) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: res = a >> b[4:0];
        3'd6: res = a | b;
        3'd7: res = a & b;
        default: res = 32'd0;
      endcase
    end
    return ok;
  endfunction

  task automatic issue(input logic [31:0] ins);
    logic        ok;
    logic [4:0]  rd;
    logic [31:0] res;
    exp_t        e;
    @(negedge i_clk);
    i_ins_valid = 1'b1;
    i_ins       = ins;
    ok = ref_exec(ins, model_regs, rd, res);
    e.illegal = !ok;
    e.rd      = rd;
    e.data    = res;
    e.edge_no = cycle + 4;  // sampled at cycle+1 and seen three edges later
    exp_q.push_back(e);
    if (ok && rd != 5'd0)
      model_regs[rd] = res;
    if (ok)
      legal_cnt++;
  endtask

  task automatic idle();
    @(negedge i_clk);
    i_ins_valid = 1'b0;
    i_ins       = 32'd0;
  endtask

  // mostly x0..x7 so hazards are frequent
  function automatic logic [4:0] pick_reg();
    if ({$random(seed)} % 8 == 0)
      return 5'($random(seed));
    return 5'({$random(seed)} % 8);
  endfunction

  function automatic logic [31:0] rand_ins();
    int          sel;
    logic [31:0] word;
    logic [6:0]  f7;
    sel  = {$random(seed)} % 16;
    word = $random(seed);
    f7   = ({$random(seed)} % 4 == 0) ? core_pkg::F7_SUB : 7'd0;
    if (sel < 7)
      return op_r(word[14:12], f7, pick_reg(), pick_reg(), pick_reg());
    else if (sel < 12)
      return op_i(word[14:12], pick_reg(), pick_reg(), word[31:20]);
    else if (sel < 15)
      return op_lui(pick_reg(), word[31:12]);
    return word;  // mostly bad encodings
  endfunction

  // retirement monitor sampling the outputs before this edge updates them
  always @(posedge i_clk) begin : monitor
    exp_t e;
    cycle = cycle + 1;
    if (!i_rst && (o_wb_valid || o_illegal)) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("retirement at %0t with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check("o_wb_valid", {31'd0, !e.illegal}, {31'd0, o_wb_valid});
        check("o_illegal", {31'd0, e.illegal}, {31'd0, o_illegal});
        if (!e.illegal) begin
          check("o_wb_rd", {27'd0, e.rd}, {27'd0, o_wb_rd});
          check("o_wb_data", e.data, o_wb_data);
        end
        check("retire edge", e.edge_no, cycle);
      end
    end
  end

  initial begin : watchdog
    while (cycle < LIMIT)
      @(negedge i_clk);
    $display("timeout after %0d cycles, retirements still missing", cycle);
    $display("Errors found");
    $finish;
  end

  initial begin : stimulus
    int i;
    i_ins_valid = 1'b0;
    i_ins       = 32'd0;
    model_regs  = '0;
    @(negedge i_rst);  // reset release
    repeat (6) idle();
    check("o_retire_cnt", 32'd0, o_retire_cnt);
    check("o_wb_valid", 32'd0, {31'd0, o_wb_valid});
    check("o_illegal", 32'd0, {31'd0, o_illegal});
    // operands first and then every op
    issue(op_i(core_pkg::F3_ADD, 5'd1, 5'd0, 12'd100));
    issue(op_i(core_pkg::F3_ADD, 5'd2, 5'd0, 12'hFF9));     // -7
    issue(op_lui(5'd3, 20'h80000));
    issue(op_i(core_pkg::F3_ADD, 5'd4, 5'd0, 12'd20));      // shift past 15
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd5, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_ADD, core_pkg::F7_SUB, 5'd6, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_AND, 7'd0, 5'd7, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_OR,  7'd0, 5'd5, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_XOR, 7'd0, 5'd6, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_SLL, 7'd0, 5'd7, 5'd1, 5'd4));
    issue(op_r(core_pkg::F3_SRL, 7'd0, 5'd5, 5'd3, 5'd4));
    issue(op_r(core_pkg::F3_SLT, 7'd0, 5'd6, 5'd2, 5'd1));  // negative < positive
    issue(op_r(core_pkg::F3_SLT, 7'd0, 5'd7, 5'd3, 5'd2));
    issue(op_i(core_pkg::F3_AND, 5'd6, 5'd2, 12'h0F0));
    issue(op_i(core_pkg::F3_OR,  5'd7, 5'd1, 12'hF00));
    issue(op_i(core_pkg::F3_XOR, 5'd5, 5'd2, 12'hFFF));
    // dependency distances 1 to 4 and the youngest of several writers
    issue(op_i(core_pkg::F3_ADD, 5'd1, 5'd0, 12'd5));
    issue(op_i(core_pkg::F3_ADD, 5'd2, 5'd1, 12'd1));
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd3, 5'd1, 5'd2));
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd4, 5'd1, 5'd3));
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd5, 5'd1, 5'd4));
    issue(op_i(core_pkg::F3_ADD, 5'd7, 5'd7, 12'd2));
    issue(op_i(core_pkg::F3_ADD, 5'd7, 5'd7, 12'd4));
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd1, 5'd7, 5'd7));
    // writes to x0 retire but leave it zero
    issue(op_i(core_pkg::F3_ADD, 5'd0, 5'd1, 12'd55));
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd2, 5'd0, 5'd0));
    issue(op_r(core_pkg::F3_OR,  7'd0, 5'd3, 5'd0, 5'd1));
    // bad encodings in line with legal ones
    issue(op_r(3'd3, 7'd0, 5'd5, 5'd1, 5'd2));              // sltu
    issue(op_r(core_pkg::F3_ADD, 7'd0, 5'd6, 5'd5, 5'd1));
    issue(32'h0000_0000);
    issue(op_r(core_pkg::F3_SRL, core_pkg::F7_SUB, 5'd6, 5'd1, 5'd2));  // sra
    issue(op_i(core_pkg::F3_SLL, 5'd6, 5'd1, 12'd3));       // slli
    issue(32'hFFFF_FFFF);
    issue(op_r(core_pkg::F3_OR, 7'd0, 5'd7, 5'd6, 5'd5));
    for (i = 0; i < N_RAND; i++) begin
      if ({$random(seed)} % 8 == 0)
        idle();
      else
        issue(rand_ins());
    end
    repeat (5) idle();
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d instructions never retired", exp_q.size());
    end
    check("o_retire_cnt", legal_cnt, o_retire_cnt);
    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: hw/bypass.sv
// register file and operand forwarding
`timescale 1ns/1ps

module bypass #(
  parameter int XLEN = 32
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic [core_pkg::REG_ADDRW-1:0] i_rs1,
  input  logic [core_pkg::REG_ADDRW-1:0] i_rs2,
  output logic [XLEN-1:0]                o_rs1_val,
  output logic [XLEN-1:0]                o_rs2_val,
  id_ex_if.dst                           id_ex,
  input  logic [XLEN-1:0]                i_ex_res,
  ex_wb_if.mon                           ex_wb,
  wb_if.dst                              wb
);

  logic [XLEN-1:0]                regs   [core_pkg::REG_COUNT];
  logic [core_pkg::REG_ADDRW-1:0] rs_idx [2];
  logic [XLEN-1:0]                rs_val [2];

  // register array write
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < core_pkg::REG_COUNT; i++)
        regs[i] <= '0;
    end else if (wb.valid && wb.rd_wen) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs_idx[0] = i_rs1;
  assign rs_idx[1] = i_rs2;

  // youngest writer wins
  for (genvar p = 0; p < 2; p++) begin : g_port
    always_comb begin
      if (rs_idx[p] == '0)
        rs_val[p] = '0;
      else if (id_ex.valid && id_ex.rd_wen && id_ex.rd == rs_idx[p])
        rs_val[p] = i_ex_res;   // distance 1
      else if (ex_wb.valid && ex_wb.rd_wen && ex_wb.rd == rs_idx[p])
        rs_val[p] = ex_wb.res;  // distance 2
      else if (wb.valid && wb.rd_wen && wb.rd == rs_idx[p])
        rs_val[p] = wb.data;    // distance 3
      else
        rs_val[p] = regs[rs_idx[p]];
    end
  end

  assign o_rs1_val = rs_val[0];
  assign o_rs2_val = rs_val[1];

  // decode drops writes to x0 three stages upstream
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    wb.valid && wb.rd_wen |-> wb.rd != '0);

endmodule

// File: hw/core_ifs.sv
// pipeline stage interfaces
`timescale 1ns/1ps

// decode to execute
interface id_ex_if #(
  parameter int XLEN = 32
);
  logic                           valid;
  core_pkg::alu_op_e              alu_op;
  logic [core_pkg::REG_ADDRW-1:0] rd;
  logic                           rd_wen;
  logic [XLEN-1:0]                op_a;
  logic [XLEN-1:0]                op_b;
  logic                           illegal;

  modport src (output valid, alu_op, rd, rd_wen, op_a, op_b, illegal);
  modport dst (input  valid, alu_op, rd, rd_wen, op_a, op_b, illegal);
endinterface

// execute to writeback
interface ex_wb_if #(
  parameter int XLEN = 32
);
  logic                           valid;
  logic [core_pkg::REG_ADDRW-1:0] rd;
  logic                           rd_wen;
  logic [XLEN-1:0]                res;
  logic                           illegal;

  modport src (output valid, rd, rd_wen, res, illegal);
  modport dst (input  valid, rd, rd_wen, res, illegal);
  modport mon (input  valid, rd, rd_wen, res);  // forwarding tap
endinterface

// writeback to register file
interface wb_if #(
  parameter int XLEN = 32
);
  logic                           valid;
  logic [core_pkg::REG_ADDRW-1:0] rd;
  logic                           rd_wen;
  logic [XLEN-1:0]                data;

  modport src (output valid, rd, rd_wen, data);
  modport dst (input  valid, rd, rd_wen, data);
endinterface

// File: hw/core_pkg.sv
// integer core definitions
package core_pkg;

  // fixed widths
  localparam int INS_W     = 32;
  localparam int REG_ADDRW = 5;
  localparam int REG_COUNT = 32;

  // major opcodes handled by decode
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // reg-reg
    OPC_OP_IMM = 7'b0010011,  // reg-imm
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // funct3 values of the supported ops
  localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;  // xor, xori
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;  // or, ori
  localparam logic [2:0] F3_AND = 3'b111;  // and, andi

  // funct7 of sub, everything else in the subset uses zero
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,     // signed compare
    ALU_PASS_B   // lui, result is op_b
  } alu_op_e;

endpackage

// File: hw/core_top.sv
// integer pipeline top
`timescale 1ns/1ps

module core_top #(
  parameter int XLEN = 32
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_ins_valid,
  input  logic [core_pkg::INS_W-1:0]     i_ins,
  output logic                           o_wb_valid,
  output logic [core_pkg::REG_ADDRW-1:0] o_wb_rd,
  output logic [XLEN-1:0]                o_wb_data,
  output logic                           o_illegal,
  output logic [31:0]                    o_retire_cnt
);

  logic [core_pkg::REG_ADDRW-1:0] idu_rs1, idu_rs2;
  logic [XLEN-1:0]                rs1_val, rs2_val;
  logic [XLEN-1:0]                ex_res;  // youngest forward

  id_ex_if #(.XLEN(XLEN)) id_ex ();
  ex_wb_if #(.XLEN(XLEN)) ex_wb ();
  wb_if    #(.XLEN(XLEN)) wb    ();

  idu #(.XLEN(XLEN)) u_idu (
    .i_clk       (i_clk      ),
    .i_rst       (i_rst      ),
    .i_ins_valid (i_ins_valid),
    .i_ins       (i_ins      ),
    .o_rs1       (idu_rs1    ),
    .o_rs2       (idu_rs2    ),
    .i_rs1_val   (rs1_val    ),
    .i_rs2_val   (rs2_val    ),
    .id_ex       (id_ex.src  )
  );

  exu #(.XLEN(XLEN)) u_exu (
    .i_clk    (i_clk    ),
    .i_rst    (i_rst    ),
    .id_ex    (id_ex.dst),
    .o_ex_res (ex_res   ),
    .ex_wb    (ex_wb.src)
  );

  wbu #(.XLEN(XLEN)) u_wbu (
    .i_clk        (i_clk       ),
    .i_rst        (i_rst       ),
    .ex_wb        (ex_wb.dst   ),
    .wb           (wb.src      ),
    .o_wb_valid   (o_wb_valid  ),
    .o_wb_rd      (o_wb_rd     ),
    .o_wb_data    (o_wb_data   ),
    .o_illegal    (o_illegal   ),
    .o_retire_cnt (o_retire_cnt)
  );

  bypass #(.XLEN(XLEN)) u_bypass (
    .i_clk     (i_clk    ),
    .i_rst     (i_rst    ),
    .i_rs1     (idu_rs1  ),
    .i_rs2     (idu_rs2  ),
    .o_rs1_val (rs1_val  ),
    .o_rs2_val (rs2_val  ),
    .id_ex     (id_ex.dst),
    .i_ex_res  (ex_res   ),
    .ex_wb     (ex_wb.mon),
    .wb        (wb.dst   )
  );

endmodule

// File: hw/exu.sv
// execute stage and alu
`timescale 1ns/1ps

module exu #(
  parameter int XLEN = 32
) (
  input  logic            i_clk,
  input  logic            i_rst,
  id_ex_if.dst            id_ex,
  output logic [XLEN-1:0] o_ex_res,
  ex_wb_if.src            ex_wb
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;

  assign shamt = id_ex.op_b[SHW-1:0];  // low bits only

  always_comb begin
    case (id_ex.alu_op)
      core_pkg::ALU_ADD:    o_ex_res = id_ex.op_a + id_ex.op_b;
      core_pkg::ALU_SUB:    o_ex_res = id_ex.op_a - id_ex.op_b;
      core_pkg::ALU_AND:    o_ex_res = id_ex.op_a & id_ex.op_b;
      core_pkg::ALU_OR:     o_ex_res = id_ex.op_a | id_ex.op_b;
      core_pkg::ALU_XOR:    o_ex_res = id_ex.op_a ^ id_ex.op_b;
      core_pkg::ALU_SLL:    o_ex_res = id_ex.op_a << shamt;
      core_pkg::ALU_SRL:    o_ex_res = id_ex.op_a >> shamt;
      core_pkg::ALU_SLT:    o_ex_res = XLEN'($signed(id_ex.op_a) < $signed(id_ex.op_b));
      core_pkg::ALU_PASS_B: o_ex_res = id_ex.op_b;
      default:              o_ex_res = '0;
    endcase
  end

  // ex/wb control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_wb.valid   <= 1'b0;
      ex_wb.rd_wen  <= 1'b0;
      ex_wb.illegal <= 1'b0;
    end else begin
      ex_wb.valid   <= id_ex.valid;
      ex_wb.rd_wen  <= id_ex.valid && id_ex.rd_wen;
      ex_wb.illegal <= id_ex.valid && id_ex.illegal;
    end
  end

  // ex/wb payload
  always_ff @(posedge i_clk) begin
    ex_wb.rd  <= id_ex.rd;
    ex_wb.res <= o_ex_res;
  end

endmodule

// File: hw/idu.sv
// instruction decode stage
`timescale 1ns/1ps

module idu #(
  parameter int XLEN = 32
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_ins_valid,
  input  logic [core_pkg::INS_W-1:0]     i_ins,
  output logic [core_pkg::REG_ADDRW-1:0] o_rs1,
  output logic [core_pkg::REG_ADDRW-1:0] o_rs2,
  input  logic [XLEN-1:0]                i_rs1_val,
  input  logic [XLEN-1:0]                i_rs2_val,
  id_ex_if.src                           id_ex
);

  core_pkg::opcode_e              opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  logic [core_pkg::REG_ADDRW-1:0] rd;
  logic [XLEN-1:0]                imm_i;
  logic [XLEN-1:0]                imm_u;
  core_pkg::alu_op_e              alu_op;
  logic [XLEN-1:0]                op_b;
  logic                           legal;

  // instruction fields
  assign opcode = core_pkg::opcode_e'(i_ins[6:0]);
  assign rd     = i_ins[11:7];
  assign funct3 = i_ins[14:12];
  assign o_rs1  = i_ins[19:15];
  assign o_rs2  = i_ins[24:20];
  assign funct7 = i_ins[31:25];

  assign imm_i = XLEN'($signed(i_ins[31:20]));           // sign extended
  assign imm_u = XLEN'($signed({i_ins[31:12], 12'b0}));

  always_comb begin
    alu_op = core_pkg::ALU_ADD;
    op_b   = i_rs2_val;
    legal  = 1'b0;
    case (opcode)
      core_pkg::OPC_OP: begin
        // only sub may carry a nonzero funct7
        legal = (funct7 == '0) ||
                (funct7 == core_pkg::F7_SUB && funct3 == core_pkg::F3_ADD);
        case (funct3)
          core_pkg::F3_ADD: alu_op = (funct7 == core_pkg::F7_SUB) ? core_pkg::ALU_SUB
                                                                   : core_pkg::ALU_ADD;
          core_pkg::F3_SLL: alu_op = core_pkg::ALU_SLL;
          core_pkg::F3_SLT: alu_op = core_pkg::ALU_SLT;
          core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_SRL: alu_op = core_pkg::ALU_SRL;
          core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
          default:          legal  = 1'b0;  // sltu
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        op_b  = imm_i;
        legal = 1'b1;
        case (funct3)
          core_pkg::F3_ADD: alu_op = core_pkg::ALU_ADD;
          core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
          default:          legal  = 1'b0;  // slti, shifts by imm
        endcase
      end
      core_pkg::OPC_LUI: begin
        alu_op = core_pkg::ALU_PASS_B;
        op_b   = imm_u;
        legal  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  // id/ex control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      id_ex.valid   <= 1'b0;
      id_ex.rd_wen  <= 1'b0;
      id_ex.illegal <= 1'b0;
    end else begin
      id_ex.valid   <= i_ins_valid;
      id_ex.rd_wen  <= i_ins_valid && legal && (rd != '0);  // x0 never written
      id_ex.illegal <= i_ins_valid && !legal;
    end
  end

  // id/ex payload
  always_ff @(posedge i_clk) begin
    id_ex.alu_op <= alu_op;
    id_ex.rd     <= rd;
    id_ex.op_a   <= i_rs1_val;
    id_ex.op_b   <= op_b;
  end

  // a bad encoding enters execute flagged and without a write
  a_illegal_no_write: assert property (@(posedge i_clk) disable iff (i_rst)
    id_ex.valid && id_ex.illegal |-> !id_ex.rd_wen);

endmodule

// File: hw/wbu.sv
// writeback stage and retire counter
`timescale 1ns/1ps

module wbu #(
  parameter int XLEN = 32
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  ex_wb_if.dst                           ex_wb,
  wb_if.src                              wb,
  output logic                           o_wb_valid,
  output logic [core_pkg::REG_ADDRW-1:0] o_wb_rd,
  output logic [XLEN-1:0]                o_wb_data,
  output logic                           o_illegal,
  output logic [31:0]                    o_retire_cnt
);

  logic retire;

  assign retire = ex_wb.valid && !ex_wb.illegal;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb.valid     <= 1'b0;
      wb.rd_wen    <= 1'b0;
      o_illegal    <= 1'b0;
      o_retire_cnt <= '0;
    end else begin
      wb.valid  <= retire;  // legal only
      wb.rd_wen <= retire && ex_wb.rd_wen;
      o_illegal <= ex_wb.valid && ex_wb.illegal;
      if (retire)
        o_retire_cnt <= o_retire_cnt + 32'd1;  // wraps
    end
  end

  always_ff @(posedge i_clk) begin
    wb.rd   <= ex_wb.rd;
    wb.data <= ex_wb.res;
  end

  assign o_wb_valid = wb.valid;
  assign o_wb_rd    = wb.rd;
  assign o_wb_data  = wb.data;

  // one outcome per retiring instruction
  a_no_both: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_wb_valid && o_illegal));

endmodule

// File: list.f
hw/core_pkg.sv
hw/core_ifs.sv
hw/idu.sv
hw/exu.sv
hw/wbu.sv
hw/bypass.sv
hw/core_top.sv
bench/tb_clk_gen.sv
bench/tb_core.sv
